// File: common/cp0_pkg.sv
package cp0_pkg;

	// cp0 register numbers
	localparam logic [4:0] CP0_BADVADDR = 5'd8;
	localparam logic [4:0] CP0_COUNT    = 5'd9;
	localparam logic [4:0] CP0_COMPARE  = 5'd11;
	localparam logic [4:0] CP0_STATUS   = 5'd12;
	localparam logic [4:0] CP0_CAUSE    = 5'd13;
	localparam logic [4:0] CP0_EPC      = 5'd14;
	localparam logic [4:0] CP0_PRID     = 5'd15;
	localparam logic [4:0] CP0_CONFIG   = 5'd16;

	localparam logic [31:0] STATUS_RESET = 32'h0040_0000; // bev only
	localparam logic [31:0] CONFIG_RESET = 32'h0000_8000;
	localparam logic [31:0] PRID_RESET   = 32'h004c_0102;

	localparam logic [31:0] EXC_VECTOR = 32'hbfc0_0380; // general vector, bev=1

	// status fields
	localparam int STATUS_IE  = 0;
	localparam int STATUS_EXL = 1;
	localparam int STATUS_IM  = 8; // lsb of im7..0

	// cause fields
	localparam int CAUSE_BD  = 31;
	localparam int CAUSE_TI  = 30;
	localparam int CAUSE_IP  = 8; // lsb of ip7..0
	localparam int CAUSE_EXC = 2; // lsb of 5-bit exccode

	// resolved exception, one per committing instruction
	typedef enum logic [4:0] {
		EXC_NONE,
		EXC_INT,
		EXC_ADEL,
		EXC_ADES,
		EXC_SYS,
		EXC_BP,
		EXC_RI,
		EXC_OV,
		EXC_TR,
		EXC_ERET
	} exc_type_e;

	// cause.exccode encodings
	typedef enum logic [4:0] {
		EXCCODE_INT  = 5'h00,
		EXCCODE_ADEL = 5'h04,
		EXCCODE_ADES = 5'h05,
		EXCCODE_SYS  = 5'h08,
		EXCCODE_BP   = 5'h09,
		EXCCODE_RI   = 5'h0a,
		EXCCODE_OV   = 5'h0c,
		EXCCODE_TR   = 5'h0d
	} exc_code_e;

endpackage

// File: common/exc_if.sv
interface exc_if import cp0_pkg::*; ();

	exc_type_e   exc_type;
	logic [31:0] pc;       // faulting instruction
	logic        in_dslot;
	logic [31:0] bad_addr;

	modport src (
		output exc_type, pc, in_dslot, bad_addr
	);

	modport dst (
		input exc_type, pc, in_dslot, bad_addr
	);

endinterface

// File: cp0/exc_resolve.sv
module exc_resolve import cp0_pkg::*; (
	input  logic        adel_if_i,
	input  logic        adel_i,
	input  logic        ades_i,
	input  logic        sys_i,
	input  logic        bp_i,
	input  logic        ri_i,
	input  logic        ov_i,
	input  logic        tr_i,
	input  logic        eret_i,
	input  logic [31:0] pc_i,
	input  logic        in_dslot_i,
	input  logic [31:0] if_addr_i,
	input  logic [31:0] mem_addr_i,
	input  logic [31:0] status_i,
	input  logic [31:0] cause_i,
	input  logic [31:0] epc_i,
	exc_if.src          exc,
	output logic        flush_o,
	output logic [31:0] new_pc_o
);

	logic      int_pending;
	logic      fetch_err; // bad address came from instruction fetch
	logic [7:0] int_masked;
	exc_type_e exc_type;

	assign int_masked  = cause_i[CAUSE_IP +: 8] & status_i[STATUS_IM +: 8];
	assign int_pending = status_i[STATUS_IE] & ~status_i[STATUS_EXL] & (|int_masked);

	// fixed priority, interrupt first
	always_comb begin
		fetch_err = 1'b0;
		if (int_pending) begin
			exc_type = EXC_INT;
		end else if (adel_if_i) begin
			exc_type  = EXC_ADEL;
			fetch_err = 1'b1;
		end else if (ri_i) begin
			exc_type = EXC_RI;
		end else if (ov_i) begin
			exc_type = EXC_OV;
		end else if (sys_i) begin
			exc_type = EXC_SYS;
		end else if (bp_i) begin
			exc_type = EXC_BP;
		end else if (tr_i) begin
			exc_type = EXC_TR;
		end else if (adel_i) begin
			exc_type = EXC_ADEL;
		end else if (ades_i) begin
			exc_type = EXC_ADES;
		end else if (eret_i) begin
			exc_type = EXC_ERET;
		end else begin
			exc_type = EXC_NONE;
		end
	end

	assign exc.exc_type = exc_type;
	assign exc.pc       = pc_i;
	assign exc.in_dslot = in_dslot_i;
	assign exc.bad_addr = fetch_err ? if_addr_i : mem_addr_i;

	assign flush_o  = (exc_type != EXC_NONE);
	assign new_pc_o = (exc_type == EXC_ERET) ? epc_i : EXC_VECTOR; // eret returns to epc

endmodule

// File: cp0/cp0_regs.sv
module cp0_regs import cp0_pkg::*; (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        stall_i,
	input  logic        we_i,
	input  logic [4:0]  waddr_i,
	input  logic [4:0]  raddr_i,
	input  logic [31:0] wdata_i,
	input  logic [5:0]  int_i,
	exc_if.dst          exc,
	output logic [31:0] rdata_o,
	output logic [31:0] status_o,
	output logic [31:0] cause_o,
	output logic [31:0] epc_o,
	output logic [31:0] count_o,
	output logic        timer_int_o
);

	logic [32:0] count_q; // count is the upper 32 bits
	logic [31:0] compare_q;
	logic [31:0] badvaddr_q;
	logic        wr_en;
	logic        commit;
	logic        timer_next;

	function automatic exc_code_e code_of(exc_type_e t);
		exc_code_e code;
		case (t)
			EXC_ADEL: code = EXCCODE_ADEL;
			EXC_ADES: code = EXCCODE_ADES;
			EXC_SYS:  code = EXCCODE_SYS;
			EXC_BP:   code = EXCCODE_BP;
			EXC_RI:   code = EXCCODE_RI;
			EXC_OV:   code = EXCCODE_OV;
			EXC_TR:   code = EXCCODE_TR;
			default:  code = EXCCODE_INT;
		endcase
		return code;
	endfunction

	assign count_o = count_q[32:1];
	assign wr_en   = we_i & ~stall_i;
	assign commit  = ~stall_i & (exc.exc_type != EXC_NONE);

	always_comb begin
		timer_next = timer_int_o;
		if (wr_en && waddr_i == CP0_COMPARE) begin
			timer_next = 1'b0; // compare write acks the timer
		end else if (compare_q != 32'd0 && count_o == compare_q) begin
			timer_next = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			count_q     <= '0;
			compare_q   <= '0;
			status_o    <= STATUS_RESET;
			cause_o     <= '0;
			epc_o       <= '0;
			timer_int_o <= 1'b0;
		end else begin
			count_q     <= count_q + 33'd1; // runs through stalls
			timer_int_o <= timer_next;
			cause_o[CAUSE_TI] <= timer_next;
			cause_o[CAUSE_IP + 2 +: 6] <= {int_i[5] | timer_next, int_i[4:0]};

			if (wr_en) begin
				case (waddr_i)
					CP0_COUNT:   count_q <= {wdata_i, 1'b0};
					CP0_COMPARE: compare_q <= wdata_i;
					CP0_STATUS:  status_o <= wdata_i;
					CP0_EPC:     epc_o <= wdata_i;
					CP0_CAUSE: begin
						cause_o[CAUSE_IP +: 2] <= wdata_i[CAUSE_IP +: 2]; // sw ip1..0
						cause_o[23:22] <= wdata_i[23:22];
					end
					default: ;
				endcase
			end

			// commit overrides a same-cycle mtc0
			if (commit) begin
				if (exc.exc_type == EXC_ERET) begin
					status_o[STATUS_EXL] <= 1'b0;
				end else begin
					if (exc.in_dslot) begin
						epc_o <= exc.pc - 32'd4; // restart at the branch
						cause_o[CAUSE_BD] <= 1'b1;
					end else begin
						epc_o <= exc.pc;
						cause_o[CAUSE_BD] <= 1'b0;
					end
					cause_o[CAUSE_EXC +: 5] <= code_of(exc.exc_type);
					status_o[STATUS_EXL] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (commit && (exc.exc_type == EXC_ADEL || exc.exc_type == EXC_ADES)) begin
			badvaddr_q <= exc.bad_addr;
		end
	end

	// mfc0
	always_comb begin
		case (raddr_i)
			CP0_BADVADDR: rdata_o = badvaddr_q;
			CP0_COUNT:    rdata_o = count_o;
			CP0_COMPARE:  rdata_o = compare_q;
			CP0_STATUS:   rdata_o = status_o;
			CP0_CAUSE:    rdata_o = cause_o;
			CP0_EPC:      rdata_o = epc_o;
			CP0_PRID:     rdata_o = PRID_RESET;
			CP0_CONFIG:   rdata_o = CONFIG_RESET;
			default:      rdata_o = 32'd0;
		endcase
	end

endmodule

// File: rtl/cp0_top.sv
module cp0_top (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        stall_i,
	input  logic        we_i,
	input  logic [4:0]  waddr_i,
	input  logic [4:0]  raddr_i,
	input  logic [31:0] wdata_i,
	input  logic [5:0]  int_i,
	input  logic        adel_if_i,
	input  logic        adel_i,
	input  logic        ades_i,
	input  logic        sys_i,
	input  logic        bp_i,
	input  logic        ri_i,
	input  logic        ov_i,
	input  logic        tr_i,
	input  logic        eret_i,
	input  logic [31:0] pc_i,
	input  logic        in_dslot_i,
	input  logic [31:0] if_addr_i,
	input  logic [31:0] mem_addr_i,
	output logic [31:0] rdata_o,
	output logic        flush_o,
	output logic [31:0] new_pc_o,
	output logic [31:0] status_o,
	output logic [31:0] cause_o,
	output logic [31:0] epc_o,
	output logic [31:0] count_o,
	output logic        timer_int_o
);

	exc_if exc_bus ();

	exc_resolve resolve_i (
		.adel_if_i(adel_if_i), .adel_i(adel_i), .ades_i(ades_i),
		.sys_i(sys_i), .bp_i(bp_i), .ri_i(ri_i),
		.ov_i(ov_i), .tr_i(tr_i), .eret_i(eret_i),
		.pc_i(pc_i), .in_dslot_i(in_dslot_i),
		.if_addr_i(if_addr_i), .mem_addr_i(mem_addr_i),
		.status_i(status_o), .cause_i(cause_o), .epc_i(epc_o), // fed back from regs
		.exc(exc_bus.src), .flush_o(flush_o), .new_pc_o(new_pc_o)
	);

	cp0_regs regs_i (
		.clk(clk), .rst_i(rst_i), .stall_i(stall_i),
		.we_i(we_i), .waddr_i(waddr_i), .raddr_i(raddr_i), .wdata_i(wdata_i),
		.int_i(int_i), .exc(exc_bus.dst),
		.rdata_o(rdata_o), .status_o(status_o), .cause_o(cause_o), .epc_o(epc_o),
		.count_o(count_o), .timer_int_o(timer_int_o)
	);

endmodule

// File: tests/cp0_assert.sv
module cp0_assert import cp0_pkg::*; (
	input logic        clk,
	input logic        rst_i,
	input logic        stall_i,
	input logic        we_i,
	input logic [4:0]  waddr_i,
	input logic        commit_i,
	input exc_type_e   exc_type_i,
	input logic [31:0] status_i,
	input logic [31:0] epc_i,
	input logic        timer_int_i
);

	logic epc_write;
	logic compare_write;

	assign epc_write     = we_i & ~stall_i & (waddr_i == CP0_EPC);
	assign compare_write = we_i & ~stall_i & (waddr_i == CP0_COMPARE);

	// epc moves only on a flush or an mtc0
	epc_needs_flush: assert property (@(posedge clk) disable iff (rst_i)
		(!commit_i && !epc_write) |=> $stable(epc_i))
		else $error("epc changed with no flush and no mtc0");

	exl_after_commit: assert property (@(posedge clk) disable iff (rst_i)
		(commit_i && exc_type_i != EXC_ERET) |=> status_i[STATUS_EXL])
		else $error("status.exl not set after an exception");

	timer_held: assert property (@(posedge clk) disable iff (rst_i)
		$fell(timer_int_i) |-> $past(compare_write))
		else $error("timer interrupt dropped without a compare write");

endmodule

bind cp0_regs cp0_assert assert_i (
	.clk(clk), .rst_i(rst_i), .stall_i(stall_i), .we_i(we_i), .waddr_i(waddr_i),
	.commit_i(commit), .exc_type_i(exc.exc_type), .status_i(status_o), .epc_i(epc_o),
	.timer_int_i(timer_int_o)
);

// File: tests/tb_cp0.sv
module tb_cp0 import cp0_pkg::*; ();

	// reset, readback, 16 exceptions, priority, interrupt, worst timer, stall
	localparam int TEST_CYCLES = 3 + 20 + 16 * 5 + 16 + 8 + (2 * 23 + 4 + 8) + 6;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 100;

	logic        clk;
	logic        rst_i;
	logic        stall_i;
	logic        we_i;
	logic [4:0]  waddr_i;
	logic [4:0]  raddr_i;
	logic [31:0] wdata_i;
	logic [5:0]  int_i;
	logic [8:0]  flags; // adel_if adel ades sys bp ri ov tr eret from the lsb
	logic [31:0] pc_i;
	logic        in_dslot_i;
	logic [31:0] if_addr_i;
	logic [31:0] mem_addr_i;
	logic [31:0] rdata_o;
	logic        flush_o;
	logic [31:0] new_pc_o;
	logic [31:0] status_o;
	logic [31:0] cause_o;
	logic [31:0] epc_o;
	logic [31:0] count_o;
	logic        timer_int_o;

	cp0_top dut_i (
		.clk(clk), .rst_i(rst_i), .stall_i(stall_i),
		.we_i(we_i), .waddr_i(waddr_i), .raddr_i(raddr_i), .wdata_i(wdata_i),
		.int_i(int_i),
		.adel_if_i(flags[0]), .adel_i(flags[1]), .ades_i(flags[2]),
		.sys_i(flags[3]), .bp_i(flags[4]), .ri_i(flags[5]),
		.ov_i(flags[6]), .tr_i(flags[7]), .eret_i(flags[8]),
		.pc_i(pc_i), .in_dslot_i(in_dslot_i), .if_addr_i(if_addr_i), .mem_addr_i(mem_addr_i),
		.rdata_o(rdata_o), .flush_o(flush_o), .new_pc_o(new_pc_o),
		.status_o(status_o), .cause_o(cause_o), .epc_o(epc_o), .count_o(count_o),
		.timer_int_o(timer_int_o)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_now($sformatf("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_code(input string what, input logic [31:0] cause, input exc_code_e exp);
		exc_code_e got;
		got = exc_code_e'(cause[CAUSE_EXC +: 5]);
		if (got !== exp) begin
			fail_now($sformatf("ERROR at %0t: %s exccode is %h, expected %h", $time, what, got, exp));
		end
	endtask

	function automatic exc_code_e flag_code(input int idx);
		exc_code_e code;
		case (idx)
			0, 1:    code = EXCCODE_ADEL; // fetch and load address errors share a code
			2:       code = EXCCODE_ADES;
			3:       code = EXCCODE_SYS;
			4:       code = EXCCODE_BP;
			5:       code = EXCCODE_RI;
			6:       code = EXCCODE_OV;
			default: code = EXCCODE_TR;
		endcase
		return code;
	endfunction

	task automatic read_reg(input logic [4:0] idx, output logic [31:0] val);
		@(negedge clk);
		raddr_i = idx;
		#1;
		val = rdata_o;
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [31:0] val);
		@(negedge clk);
		we_i = 1'b1;
		waddr_i = idx;
		wdata_i = val;
		@(negedge clk);
		we_i = 1'b0;
	endtask

	// one-cycle flag pulse that checks the combinational redirect
	task automatic raise(input logic [8:0] mask, input logic dslot, input logic [31:0] exp_pc,
			output logic [31:0] pc);
		@(negedge clk);
		pc = $urandom & 32'hffff_fffc;
		pc_i = pc;
		in_dslot_i = dslot;
		if_addr_i = $urandom;
		mem_addr_i = $urandom;
		flags = mask;
		#1;
		check_word("flush_o", {31'd0, flush_o}, 32'd1);
		check_word("new_pc_o", new_pc_o, exp_pc);
		@(negedge clk);
		flags = '0;
	endtask

	task automatic check_commit(input logic [31:0] pc, input logic dslot, input exc_code_e code);
		check_word("epc", epc_o, dslot ? pc - 32'd4 : pc);
		check_word("cause.bd", {31'd0, cause_o[CAUSE_BD]}, {31'd0, dslot});
		check_code("cause", cause_o, code);
		check_word("status.exl", {31'd0, status_o[STATUS_EXL]}, 32'd1);
	endtask

	task automatic test_reset_readback();
		logic [31:0] v;
		logic [31:0] r;
		read_reg(CP0_STATUS, r);
		check_word("status after reset", r, STATUS_RESET);
		read_reg(CP0_PRID, r);
		check_word("prid", r, PRID_RESET);
		read_reg(CP0_CONFIG, r);
		check_word("config", r, CONFIG_RESET);
		read_reg(CP0_CAUSE, r);
		check_word("cause after reset", r, 32'd0);
		read_reg(CP0_EPC, r);
		check_word("epc after reset", r, 32'd0);
		v = $urandom;
		write_reg(CP0_EPC, v);
		read_reg(CP0_EPC, r);
		check_word("epc readback", r, v);
		v = $urandom;
		write_reg(CP0_STATUS, v);
		read_reg(CP0_STATUS, r);
		check_word("status readback", r, v);
		write_reg(CP0_STATUS, STATUS_RESET);
		v = $urandom | 32'h8000_0000; // well above count
		write_reg(CP0_COMPARE, v);
		read_reg(CP0_COMPARE, r);
		check_word("compare readback", r, v);
		write_reg(CP0_COMPARE, 32'd0);
		v = $urandom;
		write_reg(CP0_CAUSE, v);
		read_reg(CP0_CAUSE, r);
		check_word("cause readback", r, v & 32'h00c0_0300); // ip1..0, bits 23..22
		write_reg(CP0_CAUSE, 32'd0);
	endtask

	task automatic test_exceptions();
		logic [31:0] pc;
		logic [31:0] r;
		logic        dslot;
		for (int i = 0; i < 8; i++) begin
			for (int d = 0; d < 2; d++) begin
				dslot = (d == 1);
				write_reg(CP0_STATUS, STATUS_RESET); // exl low before each commit
				raise(9'd1 << i, dslot, EXC_VECTOR, pc);
				check_commit(pc, dslot, flag_code(i));
				if (i < 3) begin
					read_reg(CP0_BADVADDR, r);
					check_word("badvaddr", r, (i == 0) ? if_addr_i : mem_addr_i);
				end
			end
		end
	endtask

	task automatic test_priority();
		logic [31:0] pc;
		logic [31:0] r;
		logic [31:0] e;
		raise(9'h06a, 1'b0, EXC_VECTOR, pc); // ri ov sys adel
		check_commit(pc, 1'b0, EXCCODE_RI);
		raise(9'h0a1, 1'b1, EXC_VECTOR, pc); // adel_if ri tr
		check_commit(pc, 1'b1, EXCCODE_ADEL);
		read_reg(CP0_BADVADDR, r);
		check_word("badvaddr fetch", r, if_addr_i);
		raise(9'h186, 1'b0, EXC_VECTOR, pc); // tr adel ades eret
		check_commit(pc, 1'b0, EXCCODE_TR);
		raise(9'h104, 1'b0, EXC_VECTOR, pc); // ades eret
		check_commit(pc, 1'b0, EXCCODE_ADES);
		e = pc;
		raise(9'h100, 1'b0, e, pc);
		check_word("epc after eret", epc_o, e);
		check_word("status.exl after eret", {31'd0, status_o[STATUS_EXL]}, 32'd0);
	endtask

	task automatic test_interrupt();
		logic [31:0] pc;
		@(negedge clk);
		int_i = 6'b000001; // lands in ip2
		pc = $urandom & 32'hffff_fffc;
		pc_i = pc;
		in_dslot_i = 1'b0;
		write_reg(CP0_STATUS, STATUS_RESET | 32'h0000_0401); // ie, im2
		#1;
		check_word("flush_o on interrupt", {31'd0, flush_o}, 32'd1);
		check_word("new_pc_o on interrupt", new_pc_o, EXC_VECTOR);
		@(negedge clk);
		check_commit(pc, 1'b0, EXCCODE_INT);
		int_i = 6'b000000;
		#1;
		check_word("flush_o with exl set", {31'd0, flush_o}, 32'd0);
		write_reg(CP0_STATUS, STATUS_RESET);
	endtask

	task automatic test_timer();
		logic [31:0] n;
		logic [31:0] cycles;
		n = 32'd8 + ($urandom % 32'd16);
		write_reg(CP0_COUNT, 32'd0);
		write_reg(CP0_COMPARE, n);
		cycles = 32'd0;
		while (timer_int_o !== 1'b1) begin
			if (cycles >= 2 * n + 4) begin
				fail_now("timer interrupt did not rise within the expected number of cycles");
			end
			@(negedge clk);
			cycles = cycles + 32'd1;
		end
		if (count_o < n) begin
			fail_now($sformatf("ERROR at %0t: count %0d is below compare %0d", $time, count_o, n));
		end
		check_word("cause.ti", {31'd0, cause_o[CAUSE_TI]}, 32'd1);
		write_reg(CP0_COMPARE, 32'd0);
		check_word("timer_int_o after compare write", {31'd0, timer_int_o}, 32'd0);
	endtask

	task automatic test_stall();
		logic [31:0] s;
		logic [31:0] c;
		logic [31:0] e;
		logic [31:0] k;
		@(negedge clk);
		s = status_o;
		c = cause_o;
		e = epc_o;
		k = count_o;
		stall_i = 1'b1;
		we_i = 1'b1;
		waddr_i = CP0_EPC;
		wdata_i = ~e;
		pc_i = $urandom & 32'hffff_fffc;
		flags = 9'h008; // sys
		repeat (4) @(negedge clk);
		stall_i = 1'b0;
		we_i = 1'b0;
		flags = '0;
		#1;
		check_word("epc under stall", epc_o, e);
		check_word("status under stall", status_o, s);
		check_word("cause under stall", cause_o, c);
		if (count_o == k) begin
			fail_now($sformatf("ERROR at %0t: count stuck at %0d under stall", $time, k));
		end
	endtask

	initial begin
		#(WATCHDOG_CYCLES * 10);
		fail_now("watchdog expired before the tests finished");
	end

	initial begin
		void'($urandom(32'ha7c3));
		rst_i = 1'b1;
		stall_i = 1'b0;
		we_i = 1'b0;
		waddr_i = '0;
		raddr_i = '0;
		wdata_i = '0;
		int_i = '0;
		flags = '0;
		pc_i = '0;
		in_dslot_i = 1'b0;
		if_addr_i = '0;
		mem_addr_i = '0;
		repeat (3) @(negedge clk);
		rst_i = 1'b0;
		test_reset_readback();
		test_exceptions();
		test_priority();
		test_interrupt();
		test_timer();
		test_stall();
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: project.f
common/cp0_pkg.sv
common/exc_if.sv
cp0/exc_resolve.sv
cp0/cp0_regs.sv
rtl/cp0_top.sv
tests/cp0_assert.sv
tests/tb_cp0.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_cp0 -f project.f -o sim_cp0

if ! ./obj_dir/sim_cp0 > sim.log 2>&1; then
	cat sim.log
	exit 1
fi
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
